//--- flist.f
+incdir+.
audio_pkg.sv
n64_audio_rx.sv
audio_chan_gain.sv
i2s_leftjustified_tx.sv
audio_top.sv
tb_audio_top.sv

//--- Makefile
SRCS = audio_macros.svh audio_pkg.sv n64_audio_rx.sv audio_chan_gain.sv \
       i2s_leftjustified_tx.sv audio_top.sv tb_audio_top.sv

.PHONY: run clean

run: obj_dir/Vtb_audio_top
	@out="$$(./obj_dir/Vtb_audio_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

obj_dir/Vtb_audio_top: flist.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_audio_top -f flist.f

clean:
	rm -rf obj_dir

//--- tb_audio_top.sv
// Directed testbench for the audio path with console stream driver, I2S frame capture and checks
`default_nettype none
`timescale 1ns/1ps

`include "audio_macros.svh"

module tb_audio_top;

  import audio_pkg::*;

  localparam int CLK_NS       = 4;
  // Master clocks per console sclk half, 16 per console bit
  localparam int CON_HALF_BIT = 8;
  localparam int N_RANDOM     = 3;
  // Data checks including the volume change sequence
  localparam int N_CHECKS     = 12;
  localparam int PAIRS_PER_CHK = 8;
  localparam int N_PAIRS      = N_CHECKS * PAIRS_PER_CHK + 16;
  // Four frames of 512 master clocks per pair, plus margin
  localparam longint WATCHDOG_NS =
    longint'(N_PAIRS) * 4 * 2 * `AUD_MCLK_PER_HALF * CLK_NS + 20000;

  logic                     AMCLK_i;
  logic                     nARST;
  logic                     n64_sclk;
  logic                     n64_lrclk;
  logic                     n64_sdata;
  aud_gain_t [`AUD_NCH-1:0] gain;
  logic                     asclk;
  logic                     asdata;
  logic                     alrclk;

  int          errors;
  int          checks;
  // Completed console pairs
  int          pairs_done;
  logic        stream_on;
  // Pair the stream repeats, read at the start of each pair
  aud_sample_t cur_l;
  aud_sample_t cur_r;
  integer      seed;

  audio_top dut_i (
    .AMCLK_i     (AMCLK_i),
    .nARST       (nARST),
    .n64_sclk_i  (n64_sclk),
    .n64_lrclk_i (n64_lrclk),
    .n64_sdata_i (n64_sdata),
    .gain_i      (gain),
    .ASCLK_o     (asclk),
    .ASDATA_o    (asdata),
    .ALRCLK_o    (alrclk)
  );

  initial begin
    AMCLK_i = 1'b0;
    forever #(CLK_NS / 2) AMCLK_i = ~AMCLK_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Console stream driver
  //////////////////////////////////////////////////////////////////////

  // Lands 1 ns after a rising master clock edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge AMCLK_i);
    #1;
  endtask

  // Data and word clock change while sclk is low, MSB first
  task automatic send_word(input aud_sample_t w, input logic lr);
    for (int i = `AUD_IN_W - 1; i >= 0; i--) begin
      n64_sclk  = 1'b0;
      n64_lrclk = lr;
      n64_sdata = w[i];
      wait_clks(CON_HALF_BIT);
      n64_sclk  = 1'b1;
      wait_clks(CON_HALF_BIT);
    end
  endtask

  task automatic send_pair(input aud_sample_t l, input aud_sample_t r);
    send_word(l, 1'b1);
    send_word(r, 1'b0);
    pairs_done++;
  endtask

  // Runs back to back so word clock edges keep coming
  initial begin
    wait (stream_on);
    forever begin
      send_pair(cur_l, cur_r);
    end
  end

  task automatic wait_pairs(input int n);
    int target;
    target = pairs_done + n;
    wait (pairs_done >= target);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Expected values and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Signed sample times unsigned gain, 24 bits, then 8 copies of the LSB
  function automatic logic [`AUD_SLOT_W-1:0] expect_slot(input aud_sample_t s,
                                                        input aud_gain_t g);
    int                     p;
    logic [`AUD_OUT_W-1:0]  w;
    p = int'(s) * int'(g);
    w = p[`AUD_OUT_W-1:0];
    return {w, {(`AUD_SLOT_W - `AUD_OUT_W){w[0]}}};
  endfunction

  task automatic check_slot(input logic [`AUD_SLOT_W-1:0] got, input aud_sample_t s,
                            input aud_gain_t g, input string what);
    logic [`AUD_SLOT_W-1:0] exp;
    exp = expect_slot(s, g);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s slot %h, expected %h (sample %0d, gain %0d)",
               $time, what, got, exp, s, g);
    end
  endtask

  task automatic check_idle();
    checks++;
    if (asclk !== 1'b1 || asdata !== 1'b0 || alrclk !== 1'b0) begin
      errors++;
      $display("** Error at time %0t: outputs not idle, ASCLK %b ASDATA %b ALRCLK %b",
               $time, asclk, asdata, alrclk);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // I2S capture
  //////////////////////////////////////////////////////////////////////

  // One frame from the rising ALRCLK up to the next one, 32 bits per half
  // Clock shape checked on the way
  task automatic capture_frame(output logic [`AUD_SLOT_W-1:0] left,
                               output logic [`AUD_SLOT_W-1:0] right);
    logic [2*`AUD_SLOT_W-1:0] bits;
    realtime                  last_t;
    realtime                  now_t;
    int                       exp_gap;
    @(posedge alrclk);
    last_t = $realtime;
    for (int b = 0; b < 2 * `AUD_SLOT_W; b++) begin
      @(posedge asclk);
      now_t = $realtime;
      bits  = {bits[2*`AUD_SLOT_W-2:0], asdata};
      // Left half while ALRCLK high
      check_level(alrclk, (b < `AUD_SLOT_W) ? 1'b1 : 1'b0, "ALRCLK at bit clock rise");
      // First rise comes half a bit after the word clock edge
      exp_gap = (b == 0) ? `AUD_MCLK_PER_BIT / 2 : `AUD_MCLK_PER_BIT;
      check_count(int'((now_t - last_t) / CLK_NS), exp_gap, "ASCLK spacing in master clocks");
      last_t = now_t;
    end
    // Right half ends half a bit after its 32nd bit clock rise
    @(posedge alrclk or posedge asclk);
    now_t = $realtime;
    check_level(alrclk, 1'b1, "ALRCLK after 32 right half bit clocks");
    check_count(int'((now_t - last_t) / CLK_NS), `AUD_MCLK_PER_BIT / 2,
                "ALRCLK rise after last bit clock in master clocks");
    left  = bits[2*`AUD_SLOT_W-1:`AUD_SLOT_W];
    right = bits[`AUD_SLOT_W-1:0];
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Repeat one pair, skip two whole frames, then check the next frame
  task automatic data_check(input aud_sample_t l, input aud_sample_t r,
                            input aud_gain_t gl, input aud_gain_t gr, input string what);
    logic [`AUD_SLOT_W-1:0] left_slot;
    logic [`AUD_SLOT_W-1:0] right_slot;
    wait_clks(1);
    cur_l   = l;
    cur_r   = r;
    gain[1] = gl;
    gain[0] = gr;
    wait_pairs(3);
    repeat (2) @(posedge alrclk);
    capture_frame(left_slot, right_slot);
    check_slot(left_slot, l, gl, {what, " left"});
    check_slot(right_slot, r, gr, {what, " right"});
  endtask

  task automatic random_checks();
    aud_sample_t l;
    aud_sample_t r;
    aud_gain_t   gl;
    aud_gain_t   gr;
    int          rnd;
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = $random(seed);
      l   = rnd[15:0];
      r   = rnd[31:16];
      rnd = $random(seed);
      gl  = rnd[7:0];
      gr  = rnd[15:8];
      data_check(l, r, gl, gr, "random");
    end
  endtask

  // New samples and gain start with the same pair at the receiver output
  task automatic volume_change_check();
    aud_sample_t            old_l;
    aud_sample_t            old_r;
    aud_sample_t            new_l;
    aud_sample_t            new_r;
    logic [`AUD_SLOT_W-1:0] ls;
    logic [`AUD_SLOT_W-1:0] rs;
    old_l = aud_sample_t'(1000);
    old_r = aud_sample_t'(-2000);
    new_l = aud_sample_t'(-3000);
    new_r = aud_sample_t'(4000);
    data_check(old_l, old_r, 8'd10, 8'd20, "before volume change");
    // Two bits into a pair, samples apply from the next pair
    wait_pairs(1);
    wait_clks(4 * CON_HALF_BIT);
    cur_l = new_l;
    cur_r = new_r;
    // Two bits into that next pair, after the old right word took its gain
    wait_pairs(1);
    wait_clks(4 * CON_HALF_BIT);
    gain[1] = 8'd90;
    gain[0] = 8'd70;
    for (int f = 0; f < 6; f++) begin
      capture_frame(ls, rs);
      if (f == 5) begin
        check_slot(ls, new_l, 8'd90, "after volume change left");
        check_slot(rs, new_r, 8'd70, "after volume change right");
      end else begin
        // Either the old product or the new one, never a mix
        if (ls !== expect_slot(new_l, 8'd90)) begin
          check_slot(ls, old_l, 8'd10, "during volume change left");
        end
        if (rs !== expect_slot(new_r, 8'd70)) begin
          check_slot(rs, old_r, 8'd20, "during volume change right");
        end
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    nARST      = 1'b0;
    n64_sclk   = 1'b1;
    n64_lrclk  = 1'b0;
    n64_sdata  = 1'b0;
    gain       = '0;
    stream_on  = 1'b0;
    cur_l      = '0;
    cur_r      = '0;
    errors     = 0;
    checks     = 0;
    pairs_done = 0;
    seed       = 32'h571a_942a;
    repeat (3) @(posedge AMCLK_i);
    #1;
    nARST = 1'b1;

    // Idle with no stream, then through the whole first pair
    repeat (64) begin
      wait_clks(1);
      check_idle();
    end
    cur_l     = aud_sample_t'(12345);
    cur_r     = aud_sample_t'(-7);
    gain[1]   = 8'd1;
    gain[0]   = 8'd1;
    stream_on = 1'b1;
    while (pairs_done < 1) begin
      wait_clks(1);
      check_idle();
    end

    data_check(aud_sample_t'(12345), aud_sample_t'(-7), 8'd1, 8'd1, "unity");
    data_check(aud_sample_t'(-1), aud_sample_t'(32767), 8'd1, 8'd1, "unity");
    random_checks();
    data_check(aud_sample_t'(-32768), aud_sample_t'(32767), 8'd255, 8'd255, "extremes");
    data_check(aud_sample_t'(32767), aud_sample_t'(-32768), 8'd255, 8'd255, "extremes swapped");
    data_check(aud_sample_t'(16'h1234), aud_sample_t'(-5), 8'd0, 8'd200, "independent");
    volume_change_check();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- audio_top.sv
// Audio path top level with console receiver, per-channel volume stages and I2S transmitter
`default_nettype none
`timescale 1ns/1ps

`include "audio_macros.svh"

module audio_top (
  input  logic                                      AMCLK_i,
  input  logic                                      nARST,
  // Console serial stream
  input  logic                                      n64_sclk_i,
  input  logic                                      n64_lrclk_i,
  input  logic                                      n64_sdata_i,
  // Volume, index 1 is left, index 0 is right
  input  audio_pkg::aud_gain_t [`AUD_NCH-1:0]       gain_i,
  // Left-justified I2S out
  output logic                                      ASCLK_o,
  output logic                                      ASDATA_o,
  output logic                                      ALRCLK_o
);

  import audio_pkg::*;

  // Receiver output, seen by every channel stage
  aud_in_beat_t                  rx_beat;
  // One scaled beat per channel
  aud_out_beat_t [`AUD_NCH-1:0]  chan_beat;

  n64_audio_rx u_rx (
    .AMCLK_i     (AMCLK_i),
    .nARST       (nARST),
    .n64_sclk_i  (n64_sclk_i),
    .n64_lrclk_i (n64_lrclk_i),
    .n64_sdata_i (n64_sdata_i),
    .beat_o      (rx_beat)
  );

  //////////////////////////////////////////////////////////////////////
  // Channel stages, each picks its own beats by index
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `AUD_NCH; k++) begin : g_chan
    audio_chan_gain #(
      .CH_IDX (k)
    ) u_gain (
      .AMCLK_i (AMCLK_i),
      .nARST   (nARST),
      .beat_i  (rx_beat),
      .gain_i  (gain_i[k]),
      .beat_o  (chan_beat[k])
    );
  end

  i2s_leftjustified_tx u_tx (
    .AMCLK_i  (AMCLK_i),
    .nARST    (nARST),
    .beat_i   (chan_beat),
    .ASCLK_o  (ASCLK_o),
    .ASDATA_o (ASDATA_o),
    .ALRCLK_o (ALRCLK_o)
  );

endmodule

`default_nettype wire

//--- i2s_leftjustified_tx.sv
// Left-justified I2S transmitter with per-channel holding registers and framing counter
`default_nettype none
`timescale 1ns/1ps

`include "audio_macros.svh"

module i2s_leftjustified_tx (
  input  logic                                          AMCLK_i,
  input  logic                                          nARST,
  // Index 1 is left, index 0 is right
  input  audio_pkg::aud_out_beat_t [`AUD_NCH-1:0]       beat_i,
  // Serial audio out
  output logic                                          ASCLK_o,
  output logic                                          ASDATA_o,
  output logic                                          ALRCLK_o
);

  import audio_pkg::*;

  // Master clock count within one word clock half
  localparam int CNT_W       = $clog2(`AUD_MCLK_PER_HALF);
  // Master clocks per output bit, as a bit count
  localparam int BIT_CNT_W   = $clog2(`AUD_MCLK_PER_BIT);
  // ASCLK_o toggles every half bit
  localparam int SCLK_HALF_W = BIT_CNT_W - 1;
  // Selects one of 32 slot bits
  localparam int IDX_W       = CNT_W - BIT_CNT_W;
  localparam int PAD_W       = `AUD_SLOT_W - `AUD_OUT_W;
  // New bit goes out one master clock after the falling ASCLK_o edge
  localparam logic [BIT_CNT_W-1:0] DATA_PHASE = BIT_CNT_W'(1);

  //////////////////////////////////////////////////////////////////////
  // Input holding registers
  //////////////////////////////////////////////////////////////////////

  // Latest word per channel
  aud_word_t           hold_q [`AUD_NCH];
  // Channel has delivered at least one word
  logic [`AUD_NCH-1:0] seen_q;
  // Frame runs once every channel has data
  logic                running;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      seen_q <= '0;
      for (int c = 0; c < `AUD_NCH; c++) begin
        hold_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < `AUD_NCH; c++) begin
        if (beat_i[c].valid) begin
          hold_q[c] <= beat_i[c].word;
          seen_q[c] <= 1'b1;
        end
      end
    end
  end

  assign running = &seen_q;

  //////////////////////////////////////////////////////////////////////
  // Frame timing
  //////////////////////////////////////////////////////////////////////

  // 24.576 MHz master clock, 512 clocks per 48 kHz frame
  // LRCLK high for left, low for right, 256 clocks each
  // 32 bit clocks per half, 8 master clocks each
  // LRCLK edges line up with falling bit clock edges

  logic [CNT_W-1:0] cnt_q;
  // Slot bit, MSB first
  logic [IDX_W-1:0] bit_idx;
  // Start of the left half, LRCLK about to rise
  logic             left_start;

  // Words framed for output, word followed by LSB copies
  logic [`AUD_SLOT_W-1:0] slot_q [`AUD_NCH];

  assign bit_idx    = ~cnt_q[CNT_W-1:BIT_CNT_W];
  assign left_start = running && (cnt_q == '0) && !ALRCLK_o;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST || !running) begin
      // Idle levels until both channels are filled
      cnt_q    <= '0;
      ASCLK_o  <= 1'b1;
      ASDATA_o <= 1'b0;
      ALRCLK_o <= 1'b0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(1);
      if (cnt_q[SCLK_HALF_W-1:0] == '0) begin
        ASCLK_o <= ~ASCLK_o;
      end
      if (cnt_q == '0) begin
        ALRCLK_o <= ~ALRCLK_o;
      end
      // Current half already switched at count 0
      if (cnt_q[BIT_CNT_W-1:0] == DATA_PHASE) begin
        ASDATA_o <= slot_q[ALRCLK_o][bit_idx];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot load
  //////////////////////////////////////////////////////////////////////

  // Both slots refresh together so a frame carries one left/right pair
  always_ff @(posedge AMCLK_i) begin
    if (left_start) begin
      for (int c = 0; c < `AUD_NCH; c++) begin
        slot_q[c] <= {hold_q[c], {PAD_W{hold_q[c][0]}}};
      end
    end
  end

endmodule

`default_nettype wire

//--- audio_chan_gain.sv
// Per-channel volume stage, two-cycle multiply from 16-bit sample to 24-bit word
`default_nettype none
`timescale 1ns/1ps

`include "audio_macros.svh"

module audio_chan_gain #(
  // 1 for left, 0 for right
  parameter int unsigned CH_IDX = 0
) (
  input  logic                     AMCLK_i,
  input  logic                     nARST,
  // Shared receiver beat, filtered by chan
  input  audio_pkg::aud_in_beat_t  beat_i,
  input  audio_pkg::aud_gain_t     gain_i,
  output audio_pkg::aud_out_beat_t beat_o
);

  import audio_pkg::*;

  localparam int EXT_W = `AUD_OUT_W - `AUD_IN_W;

  // Beat is for this channel
  logic accept;

  assign accept = beat_i.valid && (beat_i.chan == 1'(CH_IDX));

  //////////////////////////////////////////////////////////////////////
  // Stage 1, capture sample and gain
  //////////////////////////////////////////////////////////////////////

  logic        s1_valid_q;
  aud_sample_t s1_sample_q;
  // Gain is taken with the sample, volume changes apply per sample
  aud_gain_t   s1_gain_q;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= accept;
    end
  end

  always_ff @(posedge AMCLK_i) begin
    if (accept) begin
      s1_sample_q <= beat_i.sample;
      s1_gain_q   <= gain_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, signed multiply
  //////////////////////////////////////////////////////////////////////

  // Both operands at full word width
  // 16 x 8 bits cannot overflow 24 signed bits
  aud_word_t sample_ext;
  aud_word_t gain_ext;
  aud_word_t product;

  assign sample_ext = {{EXT_W{s1_sample_q[`AUD_IN_W-1]}}, s1_sample_q};
  // Gain is unsigned, zero-extend
  assign gain_ext   = {{(`AUD_OUT_W - `AUD_GAIN_W){1'b0}}, s1_gain_q};
  assign product    = sample_ext * gain_ext;

  logic      s2_valid_q;
  aud_word_t s2_word_q;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      s2_valid_q <= 1'b0;
    end else begin
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge AMCLK_i) begin
    if (s1_valid_q) begin
      s2_word_q <= product;
    end
  end

  assign beat_o.valid = s2_valid_q;
  assign beat_o.word  = s2_word_q;

endmodule

`default_nettype wire

//--- n64_audio_rx.sv
// Console serial audio receiver with input synchroniser and 16-bit deserialiser
`default_nettype none
`timescale 1ns/1ps

`include "audio_macros.svh"

module n64_audio_rx (
  input  logic                  AMCLK_i,
  input  logic                  nARST,
  // Console stream, asynchronous to AMCLK_i
  input  logic                  n64_sclk_i,
  input  logic                  n64_lrclk_i,
  input  logic                  n64_sdata_i,
  // One-cycle beat per completed word
  output audio_pkg::aud_in_beat_t beat_o
);

  import audio_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Synchroniser
  //////////////////////////////////////////////////////////////////////

  // Bit 0 is the metastable stage, bit 1 is safe to use
  logic [1:0] sclk_sync_q;
  logic [1:0] lrclk_sync_q;
  logic [1:0] sdata_sync_q;

  // Previous synchronised sclk level, for edge detection
  logic sclk_last_q;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      sclk_sync_q  <= '0;
      lrclk_sync_q <= '0;
      sdata_sync_q <= '0;
      sclk_last_q  <= 1'b0;
    end else begin
      sclk_sync_q  <= {sclk_sync_q[0], n64_sclk_i};
      lrclk_sync_q <= {lrclk_sync_q[0], n64_lrclk_i};
      sdata_sync_q <= {sdata_sync_q[0], n64_sdata_i};
      sclk_last_q  <= sclk_sync_q[1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word framing
  //////////////////////////////////////////////////////////////////////

  // Console samples data on its rising sclk edge
  logic sclk_rise;
  // Word clock level differs from the one seen at the last sclk rise
  logic lr_change;

  // Word clock level of the word being collected
  logic lr_last_q;
  // Set at the first word clock change, the word before it is partial
  logic started_q;
  logic valid_q;

  assign sclk_rise = sclk_sync_q[1] & ~sclk_last_q;
  assign lr_change = lrclk_sync_q[1] ^ lr_last_q;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      lr_last_q <= 1'b0;
      started_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (sclk_rise) begin
        lr_last_q <= lrclk_sync_q[1];
        if (lr_change) begin
          started_q <= 1'b1;
          // Only publish once a full word has been framed
          valid_q   <= started_q;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift register and output payload
  //////////////////////////////////////////////////////////////////////

  // MSB first, newest bit lands in bit 0
  aud_sample_t shift_q;
  aud_sample_t sample_q;
  logic        chan_q;

  always_ff @(posedge AMCLK_i) begin
    if (sclk_rise) begin
      // The bit sampled at a word clock change already belongs to the next word
      shift_q <= {shift_q[`AUD_IN_W-2:0], sdata_sync_q[1]};
      if (lr_change) begin
        sample_q <= shift_q;
        // Channel of the word just finished
        chan_q   <= lr_last_q;
      end
    end
  end

  assign beat_o.valid  = valid_q;
  assign beat_o.chan   = chan_q;
  assign beat_o.sample = sample_q;

endmodule

`default_nettype wire

//--- audio_pkg.sv
// Audio sample, word and gain types plus the input and output beat structs
`default_nettype none

`include "audio_macros.svh"

package audio_pkg;

  // Raw console sample, two's complement
  typedef logic signed [`AUD_IN_W-1:0] aud_sample_t;

  // Sample after volume, sign-extended product
  typedef logic signed [`AUD_OUT_W-1:0] aud_word_t;

  // Volume, 0 mutes and 1 is unity
  typedef logic [`AUD_GAIN_W-1:0] aud_gain_t;

  // Receiver beat, broadcast to every channel stage
  // chan 1 is left, 0 is right
  typedef struct packed {
    logic        valid;
    logic        chan;
    aud_sample_t sample;
  } aud_in_beat_t;

  // One per channel, into the transmitter
  typedef struct packed {
    logic      valid;
    aud_word_t word;
  } aud_out_beat_t;

endpackage

`default_nettype wire

//--- audio_macros.svh
// Sample, slot and gain widths, channel count and I2S master clock timing
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// Console sample width, signed
`define AUD_IN_W 16
// Scaled word width after the volume stage
`define AUD_OUT_W 24
// Slot width on the I2S side, word plus LSB padding
`define AUD_SLOT_W 32
// Left and right
`define AUD_NCH 2
// Per-channel volume, unsigned
`define AUD_GAIN_W 8

// 24.576 MHz master clock gives 512 per 48 kHz frame
`define AUD_MCLK_PER_HALF 256
`define AUD_MCLK_PER_BIT 8

`endif
